// ==== hw/l2_cache_params.svh ====
`ifndef L2_CACHE_PARAMS_SVH
`define L2_CACHE_PARAMS_SVH

// Core side address and data path
`define L2_ADDR_W       32
`define L2_WORD_W       32
`define L2_STRB_W       4

// Line geometry, 8 words of 4 bytes
`define L2_LINE_BYTES   32
`define L2_LINE_WORDS   8
`define L2_OFFS_W       5

// 64 sets, two ways per set
`define L2_SET_W        6

// Address bits above set index and offset
`define L2_TAG_W        21

`endif

// ==== hw/l2_cache_pkg.sv ====
`default_nettype none

`include "l2_cache_params.svh"

package l2_cache_pkg;

    // Address fields
    typedef logic [`L2_ADDR_W-1:0]              addr_t;
    typedef logic [`L2_SET_W-1:0]               set_idx_t;
    typedef logic [`L2_TAG_W-1:0]               tag_t;
    typedef logic [$clog2(`L2_LINE_WORDS)-1:0]  word_sel_t;

    // Way number, two ways
    typedef logic                               way_t;

    // Data path
    typedef logic [`L2_LINE_BYTES*8-1:0]        line_t;
    typedef logic [`L2_WORD_W-1:0]              word_t;
    typedef logic [`L2_STRB_W-1:0]              strb_t;

    // One stored entry per set and way
    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } tag_entry_t;

    typedef enum logic [2:0] {
        ST_RESET,
        ST_LOOKUP,
        ST_EVICT,
        ST_EVICT_WAIT,
        ST_REFILL,
        ST_READ,
        ST_WRITE
    } cache_state_t;

endpackage

`default_nettype wire

// ==== hw/l2_bus_pkg.sv ====
`default_nettype none

package l2_bus_pkg;

    import l2_cache_pkg::*;

    // Core side, a write is any nonzero strobe
    typedef struct packed {
        logic  rd;
        strb_t strb;
        addr_t addr;
        word_t wdata;
    } core_req_t;

    typedef struct packed {
        logic  ack;
        logic  error;
        word_t rdata;
    } core_resp_t;

    // Memory side moves whole lines at line-aligned addresses
    typedef struct packed {
        logic  rd;
        logic  wr;
        addr_t addr;
        line_t wdata;
    } mem_req_t;

    typedef struct packed {
        logic  ack;
        logic  error;
        line_t rdata;
    } mem_resp_t;

endpackage

`default_nettype wire

// ==== hw/l2_tag_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module l2_tag_array
(
    input  wire                              clk_i,
    input  wire l2_cache_pkg::set_idx_t      rd_set_i,
    input  wire l2_cache_pkg::set_idx_t      wr_set_i,
    input  wire [1:0]                        tag_wr_i,
    input  wire l2_cache_pkg::tag_entry_t    tag_entry_i,
    input  wire l2_cache_pkg::tag_t          req_tag_i,
    input  wire l2_cache_pkg::way_t          victim_way_i,
    output logic [1:0]                       hit_o,
    output logic                             victim_dirty_o,
    output l2_cache_pkg::tag_t               victim_tag_o
);

    import l2_cache_pkg::*;

    localparam int NUM_SETS = 2 ** $bits(set_idx_t);

    tag_entry_t tag_mem [2][NUM_SETS];
    tag_entry_t rd_entry_q [2];

    // --------------------------------------------------
    // Storage, one cycle read
    // --------------------------------------------------
    always_ff @(posedge clk_i)
    begin
        for (int w = 0; w < 2; w++)
        begin
            if (tag_wr_i[w])
                tag_mem[w][wr_set_i] <= tag_entry_i;

            // Same-set write goes straight to the read port so a new dirty bit is seen
            if (tag_wr_i[w] && (wr_set_i == rd_set_i))
                rd_entry_q[w] <= tag_entry_i;
            else
                rd_entry_q[w] <= tag_mem[w][rd_set_i];
        end
    end

    // --------------------------------------------------
    // Compare
    // --------------------------------------------------
    always_comb
    begin
        for (int w = 0; w < 2; w++)
            hit_o[w] = rd_entry_q[w].valid && (rd_entry_q[w].tag == req_tag_i);
    end

    // Victim needs a write back only when valid and dirty
    assign victim_dirty_o = rd_entry_q[victim_way_i].valid && rd_entry_q[victim_way_i].dirty;
    assign victim_tag_o   = rd_entry_q[victim_way_i].tag;

    // A refill only ever allocates a tag that missed in both ways
    a_single_hit: assert property (@(posedge clk_i)
        !$isunknown(hit_o) |-> $onehot0(hit_o));

endmodule

`default_nettype wire

// ==== hw/l2_data_array.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "l2_cache_params.svh"

module l2_data_array
(
    input  wire                              clk_i,
    input  wire l2_cache_pkg::set_idx_t      rd_set_i,
    input  wire l2_cache_pkg::set_idx_t      wr_set_i,
    input  wire [1:0][`L2_LINE_BYTES-1:0]    mask_i,
    input  wire l2_cache_pkg::word_t         word_i,
    input  wire                              refill_i,
    input  wire l2_cache_pkg::line_t         refill_line_i,
    input  wire l2_cache_pkg::word_sel_t     word_sel_i,
    input  wire [1:0]                        hit_i,
    input  wire l2_cache_pkg::way_t          victim_way_i,
    output l2_cache_pkg::word_t              rdata_o,
    output l2_cache_pkg::line_t              victim_line_o
);

    import l2_cache_pkg::*;

    localparam int NUM_SETS = 2 ** $bits(set_idx_t);

    line_t     data_mem [2][NUM_SETS];
    line_t     rd_line_q [2];
    line_t     wr_line;
    word_sel_t sel_q;
    word_t     way_word [2];

    // Refill brings a full line, a core write is copied into every word slot
    assign wr_line = refill_i ? refill_line_i : {`L2_LINE_WORDS{word_i}};

    // --------------------------------------------------
    // Byte masked storage
    // --------------------------------------------------
    always_ff @(posedge clk_i)
    begin
        for (int w = 0; w < 2; w++)
        begin
            for (int b = 0; b < `L2_LINE_BYTES; b++)
            begin
                if (mask_i[w][b])
                    data_mem[w][wr_set_i][b*8 +: 8] <= wr_line[b*8 +: 8];
            end
            rd_line_q[w] <= data_mem[w][rd_set_i];
        end
        sel_q <= word_sel_i;
    end

    // --------------------------------------------------
    // Read word select
    // --------------------------------------------------
    always_comb
    begin
        for (int w = 0; w < 2; w++)
            way_word[w] = rd_line_q[w][sel_q*`L2_WORD_W +: `L2_WORD_W];
    end

    // And-or mux, zero when neither way hit
    assign rdata_o = (way_word[0] & {`L2_WORD_W{hit_i[0]}}) |
                     (way_word[1] & {`L2_WORD_W{hit_i[1]}});

    assign victim_line_o = rd_line_q[victim_way_i];

endmodule

`default_nettype wire

// ==== hw/l2_cache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "l2_cache_params.svh"

module l2_cache_ctrl
(
    input  wire                              clk_i,
    input  wire                              rst_i,
    // Core side
    input  wire l2_bus_pkg::core_req_t       core_req_i,
    output logic                             core_accept_o,
    output logic                             core_ack_o,
    output logic                             core_error_o,
    // Memory side
    output l2_bus_pkg::mem_req_t             mem_req_o,
    input  wire                              mem_accept_i,
    input  wire                              mem_ack_i,
    input  wire                              mem_error_i,
    // Array control
    output l2_cache_pkg::set_idx_t           rd_set_o,
    output l2_cache_pkg::set_idx_t           wr_set_o,
    output logic [1:0]                       tag_wr_o,
    output l2_cache_pkg::tag_entry_t         tag_entry_o,
    input  wire [1:0]                        hit_i,
    input  wire                              victim_dirty_i,
    input  wire l2_cache_pkg::tag_t          victim_tag_i,
    input  wire l2_cache_pkg::line_t         victim_line_i,
    output l2_cache_pkg::way_t               replace_way_o,
    output logic [1:0][`L2_LINE_BYTES-1:0]   data_mask_o,
    output l2_cache_pkg::word_sel_t          data_sel_o,
    output l2_cache_pkg::word_t              wdata_o,
    output logic                             refill_o
);

    import l2_cache_pkg::*;
    import l2_bus_pkg::*;

    localparam int BYTE_W = $clog2(`L2_STRB_W);
    localparam int SEL_W  = $bits(word_sel_t);
    localparam int TAG_LO = `L2_OFFS_W + `L2_SET_W;

    cache_state_t state_q;
    cache_state_t next_state;

    core_req_t  req_q;
    logic       req_write;
    logic       req_valid;
    logic       req_miss;
    set_idx_t   req_set;
    tag_t       req_tag;
    word_sel_t  req_sel;
    logic       same_word;

    set_idx_t   sweep_q;
    way_t       replace_way_q;
    logic       refill_sent_q;
    logic       refill_req;
    logic       error_q;
    logic [`L2_LINE_BYTES-1:0] word_mask;

    assign req_write = |req_q.strb;
    assign req_valid = req_q.rd || req_write;
    assign req_miss  = req_valid && !(|hit_i);
    assign req_set   = req_q.addr[`L2_OFFS_W +: `L2_SET_W];
    assign req_tag   = req_q.addr[TAG_LO +: `L2_TAG_W];
    assign req_sel   = req_q.addr[BYTE_W +: SEL_W];

    // --------------------------------------------------
    // Core handshake
    // --------------------------------------------------
    // Read of the word just written must wait for the write to land
    assign same_word = req_write && core_req_i.rd &&
        (core_req_i.addr[`L2_ADDR_W-1:BYTE_W] == req_q.addr[`L2_ADDR_W-1:BYTE_W]);

    assign core_accept_o = (state_q == ST_LOOKUP) && !req_miss && !same_word;
    assign core_ack_o    = (state_q == ST_LOOKUP) && req_valid && (|hit_i);
    assign core_error_o  = error_q;

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            req_q <= '0;
        else if (core_accept_o)
            req_q <= core_req_i;
        else if (core_ack_o)
            req_q <= '0;
    end

    // --------------------------------------------------
    // State machine
    // --------------------------------------------------
    always_comb
    begin
        next_state = state_q;
        case (state_q)
            ST_RESET:
                if (&sweep_q)
                    next_state = ST_LOOKUP;
            ST_LOOKUP:
                if (req_miss)
                    next_state = victim_dirty_i ? ST_EVICT : ST_REFILL;
            ST_EVICT:
                if (mem_accept_i)
                    next_state = ST_EVICT_WAIT;
            ST_EVICT_WAIT:
                if (mem_ack_i)
                    next_state = ST_REFILL;
            ST_REFILL:
                if (mem_ack_i)
                    next_state = req_write ? ST_WRITE : ST_READ;
            ST_READ, ST_WRITE:
                next_state = ST_LOOKUP;
            default:
                next_state = ST_RESET;
        endcase
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            state_q       <= ST_RESET;
            sweep_q       <= '0;
            replace_way_q <= 1'b0;
            refill_sent_q <= 1'b0;
        end
        else
        begin
            state_q <= next_state;
            if (state_q == ST_RESET)
                sweep_q <= sweep_q + 1'b1;
            // Round robin moves on once a miss has finished
            if (state_q == ST_READ || state_q == ST_WRITE)
                replace_way_q <= ~replace_way_q;
            if (refill_req && mem_accept_i)
                refill_sent_q <= 1'b1;
            else if (state_q == ST_REFILL && mem_ack_i)
                refill_sent_q <= 1'b0;
        end
    end

    // Set by a memory error, cleared once the core has seen it
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            error_q <= 1'b0;
        else if (mem_ack_i && mem_error_i)
            error_q <= 1'b1;
        else if (core_ack_o)
            error_q <= 1'b0;
    end

    // --------------------------------------------------
    // Memory request
    // --------------------------------------------------
    assign refill_req = (state_q == ST_REFILL) && !refill_sent_q;

    always_comb
    begin
        mem_req_o.rd    = refill_req;
        mem_req_o.wr    = (state_q == ST_EVICT);
        mem_req_o.addr  = refill_req ? {req_tag, req_set, {`L2_OFFS_W{1'b0}}}
                                     : {victim_tag_i, req_set, {`L2_OFFS_W{1'b0}}};
        mem_req_o.wdata = victim_line_i;
    end

    // --------------------------------------------------
    // Array control
    // --------------------------------------------------
    // Read side follows the incoming request whenever it can be taken
    assign rd_set_o      = core_accept_o ? core_req_i.addr[`L2_OFFS_W +: `L2_SET_W] : req_set;
    assign data_sel_o    = core_accept_o ? core_req_i.addr[BYTE_W +: SEL_W] : req_sel;
    assign wr_set_o      = (state_q == ST_RESET) ? sweep_q : req_set;
    assign wdata_o       = req_q.wdata;
    assign refill_o      = (state_q == ST_REFILL);
    assign replace_way_o = replace_way_q;

    always_comb
    begin
        word_mask = '0;
        word_mask[req_sel*`L2_STRB_W +: `L2_STRB_W] = req_q.strb;
        tag_wr_o    = 2'b00;
        tag_entry_o = '{valid: 1'b1, dirty: 1'b1, tag: req_tag};
        data_mask_o = '0;
        case (state_q)
            ST_RESET:
            begin
                tag_wr_o          = 2'b11;
                tag_entry_o.valid = 1'b0;
                tag_entry_o.dirty = 1'b0;
            end
            ST_LOOKUP:
            begin
                // Write hit, merge bytes and mark dirty
                if (req_write)
                begin
                    tag_wr_o = hit_i;
                    for (int w = 0; w < 2; w++)
                        data_mask_o[w] = word_mask & {`L2_LINE_BYTES{hit_i[w]}};
                end
            end
            ST_REFILL:
            begin
                if (mem_ack_i)
                begin
                    tag_wr_o[replace_way_q]    = 1'b1;
                    tag_entry_o.dirty          = 1'b0;
                    data_mask_o[replace_way_q] = '1;
                end
            end
            ST_WRITE:
            begin
                tag_wr_o[replace_way_q]    = 1'b1;
                data_mask_o[replace_way_q] = word_mask;
            end
            default:
                ;
        endcase
    end

    a_mem_rd_wr_excl: assert property (@(posedge clk_i) disable iff (rst_i)
        !(mem_req_o.rd && mem_req_o.wr));

    // Pending memory request keeps address and data until taken
    a_mem_req_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        (mem_req_o.rd || mem_req_o.wr) && !mem_accept_i |=> $stable(mem_req_o));

endmodule

`default_nettype wire

// ==== hw/l2_cache_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "l2_cache_params.svh"

module l2_cache_core
(
    input  wire                              clk_i,
    input  wire                              rst_i,
    input  wire l2_bus_pkg::core_req_t       core_req_i,
    output logic                             core_accept_o,
    output l2_bus_pkg::core_resp_t           core_resp_o,
    output l2_bus_pkg::mem_req_t             mem_req_o,
    input  wire                              mem_accept_i,
    input  wire l2_bus_pkg::mem_resp_t       mem_resp_i
);

    import l2_cache_pkg::*;

    set_idx_t   rd_set;
    set_idx_t   wr_set;
    logic [1:0] tag_wr;
    tag_entry_t tag_entry;
    logic [1:0] hit;
    logic       victim_dirty;
    tag_t       victim_tag;
    line_t      victim_line;
    way_t       replace_way;
    logic [1:0][`L2_LINE_BYTES-1:0] data_mask;
    word_sel_t  data_sel;
    word_t      wdata;
    logic       refill;
    logic       core_ack;
    logic       core_error;
    word_t      hit_word;

    assign core_resp_o = '{ack: core_ack, error: core_error, rdata: hit_word};

    l2_cache_ctrl u_ctrl
    (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .core_req_i     (core_req_i),
        .core_accept_o  (core_accept_o),
        .core_ack_o     (core_ack),
        .core_error_o   (core_error),
        .mem_req_o      (mem_req_o),
        .mem_accept_i   (mem_accept_i),
        .mem_ack_i      (mem_resp_i.ack),
        .mem_error_i    (mem_resp_i.error),
        .rd_set_o       (rd_set),
        .wr_set_o       (wr_set),
        .tag_wr_o       (tag_wr),
        .tag_entry_o    (tag_entry),
        .hit_i          (hit),
        .victim_dirty_i (victim_dirty),
        .victim_tag_i   (victim_tag),
        .victim_line_i  (victim_line),
        .replace_way_o  (replace_way),
        .data_mask_o    (data_mask),
        .data_sel_o     (data_sel),
        .wdata_o        (wdata),
        .refill_o       (refill)
    );

    // Lookup tag is the tag field the controller writes
    l2_tag_array u_tags
    (
        .clk_i          (clk_i),
        .rd_set_i       (rd_set),
        .wr_set_i       (wr_set),
        .tag_wr_i       (tag_wr),
        .tag_entry_i    (tag_entry),
        .req_tag_i      (tag_entry.tag),
        .victim_way_i   (replace_way),
        .hit_o          (hit),
        .victim_dirty_o (victim_dirty),
        .victim_tag_o   (victim_tag)
    );

    l2_data_array u_data
    (
        .clk_i          (clk_i),
        .rd_set_i       (rd_set),
        .wr_set_i       (wr_set),
        .mask_i         (data_mask),
        .word_i         (wdata),
        .refill_i       (refill),
        .refill_line_i  (mem_resp_i.rdata),
        .word_sel_i     (data_sel),
        .hit_i          (hit),
        .victim_way_i   (replace_way),
        .rdata_o        (hit_word),
        .victim_line_o  (victim_line)
    );

endmodule

`default_nettype wire

// ==== verif/tb_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen
#(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 4
)
(
    output logic clk_o,
    output logic rst_o
);

    initial
    begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Reset drops on a rising edge like any other synchronous input
    initial
    begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_o <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== verif/tb_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "l2_cache_params.svh"

module tb_mem_model
(
    input  wire                          clk_i,
    input  wire                          rst_i,
    input  wire l2_bus_pkg::mem_req_t    mem_req_i,
    output logic                         mem_accept_o = 1'b0,
    output l2_bus_pkg::mem_resp_t        mem_resp_o = '0,
    input  wire l2_cache_pkg::addr_t     err_addr_i,
    output int                           rd_count_o = 0,
    output int                           wr_count_o = 0,
    output l2_cache_pkg::addr_t          last_wr_addr_o = '0,
    output l2_cache_pkg::line_t          last_wr_line_o = '0
);

    import l2_cache_pkg::*;
    import l2_bus_pkg::*;

    localparam int ACK_DELAY = 3;

    // Sparse backing store keyed by line address
    line_t mem_q [addr_t];

    logic  busy_q = 1'b0;
    int    cnt_q = 0;
    logic  pend_rd_q = 1'b0;
    addr_t pend_addr_q = '0;
    logic  req_valid;

    assign req_valid = mem_req_i.rd || mem_req_i.wr;

    // Untouched words hold their own address XOR a fixed pattern
    function automatic line_t stored_line(input addr_t base);
        line_t l;
        if (mem_q.exists(base))
            return mem_q[base];
        for (int i = 0; i < `L2_LINE_WORDS; i++)
            l[i*`L2_WORD_W +: `L2_WORD_W] = (base + addr_t'(i * 4)) ^ 32'h5a5a0000;
        return l;
    endfunction

    // --------------------------------------------------
    // Accept one cycle after a request shows and ack later
    // --------------------------------------------------
    always @(posedge clk_i)
    begin
        if (rst_i)
        begin
            mem_accept_o <= 1'b0;
            mem_resp_o   <= '0;
            busy_q       <= 1'b0;
            cnt_q        <= 0;
            rd_count_o   <= 0;
            wr_count_o   <= 0;
        end
        else
        begin
            mem_resp_o <= '0;
            if (mem_accept_o && req_valid)
            begin
                mem_accept_o <= 1'b0;
                busy_q       <= 1'b1;
                cnt_q        <= ACK_DELAY;
                pend_rd_q    <= mem_req_i.rd;
                pend_addr_q  <= mem_req_i.addr;
                if (mem_req_i.wr)
                begin
                    mem_q[mem_req_i.addr] = mem_req_i.wdata;
                    wr_count_o     <= wr_count_o + 1;
                    last_wr_addr_o <= mem_req_i.addr;
                    last_wr_line_o <= mem_req_i.wdata;
                end
                else
                    rd_count_o <= rd_count_o + 1;
            end
            else if (!busy_q && req_valid)
                mem_accept_o <= 1'b1;

            if (busy_q)
            begin
                if (cnt_q == 1)
                begin
                    busy_q           <= 1'b0;
                    mem_resp_o.ack   <= 1'b1;
                    mem_resp_o.error <= (pend_addr_q == err_addr_i);
                    mem_resp_o.rdata <= pend_rd_q ? stored_line(pend_addr_q) : '0;
                end
                else
                    cnt_q <= cnt_q - 1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verif/tb_l2_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "l2_cache_params.svh"

module tb_l2_cache;

    import l2_cache_pkg::*;
    import l2_bus_pkg::*;

    localparam int WAIT_LIMIT  = 200;
    localparam int SWEEP_LIMIT = 300;

    logic        clk;
    logic        rst;
    core_req_t   core_req;
    logic        core_accept;
    core_resp_t  core_resp;
    mem_req_t    mem_req;
    logic        mem_accept;
    mem_resp_t   mem_resp;
    addr_t       err_addr;
    int          mem_rd_count;
    int          mem_wr_count;
    addr_t       last_wr_addr;
    line_t       last_wr_line;

    logic [31:0] lcg_state;
    int          cycle = 0;
    int          n_tests = 0;
    int          n_checks = 0;
    int          n_errors = 0;
    int          test_err0 = 0;
    addr_t       hit_line_addr;

    core_resp_t  ack_resp_q [$];
    int          ack_cyc_q [$];

    tb_clk_gen #(.PERIOD_NS(100), .RESET_CYCLES(4)) u_clk
    (
        .clk_o (clk),
        .rst_o (rst)
    );

    l2_cache_core dut
    (
        .clk_i         (clk),
        .rst_i         (rst),
        .core_req_i    (core_req),
        .core_accept_o (core_accept),
        .core_resp_o   (core_resp),
        .mem_req_o     (mem_req),
        .mem_accept_i  (mem_accept),
        .mem_resp_i    (mem_resp)
    );

    tb_mem_model u_mem
    (
        .clk_i          (clk),
        .rst_i          (rst),
        .mem_req_i      (mem_req),
        .mem_accept_o   (mem_accept),
        .mem_resp_o     (mem_resp),
        .err_addr_i     (err_addr),
        .rd_count_o     (mem_rd_count),
        .wr_count_o     (mem_wr_count),
        .last_wr_addr_o (last_wr_addr),
        .last_wr_line_o (last_wr_line)
    );

    always @(posedge clk)
        cycle <= cycle + 1;

    // Every core ack is queued with its cycle number
    always @(negedge clk)
    begin
        if (!rst && core_resp.ack)
        begin
            ack_resp_q.push_back(core_resp);
            ack_cyc_q.push_back(cycle);
        end
    end

    // --------------------------------------------------
    // Expected values and stimulus helpers
    // --------------------------------------------------
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Random word address placed in a chosen set
    function automatic addr_t rand_addr(input set_idx_t set);
        addr_t a;
        a = lcg_next();
        a[`L2_OFFS_W +: `L2_SET_W] = set;
        a[1:0] = 2'b00;
        return a;
    endfunction

    function automatic addr_t line_base(input addr_t a);
        return {a[`L2_ADDR_W-1:`L2_OFFS_W], {`L2_OFFS_W{1'b0}}};
    endfunction

    function automatic word_t init_word(input addr_t a);
        return {a[`L2_ADDR_W-1:2], 2'b00} ^ 32'h5a5a0000;
    endfunction

    function automatic line_t init_line(input addr_t base);
        line_t l;
        for (int i = 0; i < `L2_LINE_WORDS; i++)
            l[i*`L2_WORD_W +: `L2_WORD_W] = init_word(base + addr_t'(i * 4));
        return l;
    endfunction

    function automatic word_t merge_bytes(input word_t old_w, input word_t new_w, input strb_t s);
        word_t w;
        w = old_w;
        for (int b = 0; b < `L2_STRB_W; b++)
        begin
            if (s[b])
                w[b*8 +: 8] = new_w[b*8 +: 8];
        end
        return w;
    endfunction

    function automatic core_req_t read_req(input addr_t a);
        return '{rd: 1'b1, strb: '0, addr: a, wdata: '0};
    endfunction

    function automatic core_req_t write_req(input addr_t a, input strb_t s, input word_t d);
        return '{rd: 1'b0, strb: s, addr: a, wdata: d};
    endfunction

    // --------------------------------------------------
    // Compare and report
    // --------------------------------------------------
    task automatic check_word(input string name, input word_t got, input word_t exp);
        n_checks++;
        if (got !== exp)
        begin
            n_errors++;
            $display("MISMATCH %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_line(input string name, input line_t got, input line_t exp);
        n_checks++;
        if (got !== exp)
        begin
            n_errors++;
            $display("MISMATCH %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        n_checks++;
        if (got !== exp)
        begin
            n_errors++;
            $display("MISMATCH %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        n_errors++;
        $display("timeout while waiting for %s", what);
    endtask

    task automatic finish_test(input string name);
        n_tests++;
        if (n_errors == test_err0)
            $display("test %s: ok", name);
        else
            $display("test %s: %0d errors", name, n_errors - test_err0);
        test_err0 = n_errors;
    endtask

    // --------------------------------------------------
    // Core side handshake
    // --------------------------------------------------
    // Returns at the falling edge where the request is seen accepted
    task automatic send_req(input core_req_t req, output int acc_cyc);
        int n;
        n = 0;
        @(posedge clk);
        core_req <= req;
        @(negedge clk);
        while (!core_accept && n < WAIT_LIMIT)
        begin
            @(negedge clk);
            n++;
        end
        if (!core_accept)
            report_timeout("core_accept_o");
        acc_cyc = cycle;
    endtask

    task automatic drive_idle();
        @(posedge clk);
        core_req <= '0;
    endtask

    task automatic wait_ack(output core_resp_t resp, output int ack_cyc);
        int n;
        n = 0;
        resp = '0;
        ack_cyc = -1;
        while (ack_resp_q.size() == 0 && n < WAIT_LIMIT)
        begin
            @(negedge clk);
            n++;
        end
        if (ack_resp_q.size() == 0)
            report_timeout("core_resp_o.ack");
        else
        begin
            resp = ack_resp_q.pop_front();
            ack_cyc = ack_cyc_q.pop_front();
        end
    endtask

    // One request at a time with its ack
    task automatic access(input core_req_t req, output core_resp_t resp, output int lat);
        int acc;
        int ack;
        send_req(req, acc);
        drive_idle();
        wait_ack(resp, ack);
        lat = ack - acc;
    endtask

    // --------------------------------------------------
    // Tests
    // --------------------------------------------------
    task automatic reset_sequence();
        int n;
        n = 0;
        @(negedge clk);
        while (rst && n < WAIT_LIMIT)
        begin
            @(negedge clk);
            n++;
        end
        @(negedge clk);
        check_flag("core_accept_o", core_accept, 1'b0);
        check_flag("core_resp_o.ack", core_resp.ack, 1'b0);
        check_flag("core_resp_o.error", core_resp.error, 1'b0);
        check_flag("mem_req_o.rd", mem_req.rd, 1'b0);
        check_flag("mem_req_o.wr", mem_req.wr, 1'b0);
        n = 0;
        while (!core_accept && n < SWEEP_LIMIT)
        begin
            @(negedge clk);
            n++;
        end
        if (!core_accept)
            report_timeout("core_accept_o after the tag sweep");
        finish_test("reset_sequence");
    endtask

    task automatic read_miss_then_hit();
        addr_t      a;
        core_resp_t r;
        int         rd0;
        int         lat;
        a = rand_addr(6'd1);
        hit_line_addr = a;
        rd0 = mem_rd_count;
        access(read_req(a), r, lat);
        check_word("core_resp_o.rdata", r.rdata, init_word(a));
        check_flag("core_resp_o.error", r.error, 1'b0);
        check_word("mem read count", word_t'(mem_rd_count - rd0), 32'd1);
        // Other word of the same line
        a = a ^ 32'h0000_000c;
        access(read_req(a), r, lat);
        check_word("core_resp_o.rdata", r.rdata, init_word(a));
        check_word("mem read count", word_t'(mem_rd_count - rd0), 32'd1);
        check_flag("read hit ack next cycle", lat == 1, 1'b1);
        finish_test("read_miss_then_hit");
    endtask

    task automatic write_hit_merge();
        addr_t      a;
        word_t      d;
        core_resp_t rw;
        core_resp_t rr;
        int         acc_w;
        int         acc_r;
        int         ack_w;
        int         ack_r;
        a = hit_line_addr ^ 32'h0000_0004;
        d = lcg_next();
        // Read right behind the write to the same word
        send_req(write_req(a, 4'b0101, d), acc_w);
        send_req(read_req(a), acc_r);
        drive_idle();
        wait_ack(rw, ack_w);
        wait_ack(rr, ack_r);
        check_flag("write hit ack next cycle", ack_w == acc_w + 1, 1'b1);
        check_flag("read held until write ack", acc_r > ack_w, 1'b1);
        check_flag("read hit ack next cycle", ack_r == acc_r + 1, 1'b1);
        check_word("core_resp_o.rdata", rr.rdata, merge_bytes(init_word(a), d, 4'b0101));
        finish_test("write_hit_merge");
    endtask

    task automatic write_miss_merge();
        addr_t      a;
        word_t      d;
        core_resp_t r;
        int         rd0;
        int         lat;
        a = rand_addr(6'd4);
        d = lcg_next();
        rd0 = mem_rd_count;
        access(write_req(a, 4'b1110, d), r, lat);
        check_flag("core_resp_o.error", r.error, 1'b0);
        check_word("mem read count", word_t'(mem_rd_count - rd0), 32'd1);
        access(read_req(a), r, lat);
        check_word("core_resp_o.rdata", r.rdata, merge_bytes(init_word(a), d, 4'b1110));
        check_flag("read hit ack next cycle", lat == 1, 1'b1);
        finish_test("write_miss_merge");
    endtask

    task automatic same_set_eviction();
        addr_t      a [3];
        word_t      d [3];
        core_resp_t r;
        line_t      exp_line;
        int         wr0;
        int         lat;
        wr0 = mem_wr_count;
        for (int i = 0; i < 3; i++)
        begin
            a[i] = rand_addr(6'd5);
            d[i] = lcg_next();
            access(write_req(a[i], 4'b1111, d[i]), r, lat);
        end
        // Third line pushes out the dirty first line
        check_word("mem write count", word_t'(mem_wr_count - wr0), 32'd1);
        check_word("written back address", last_wr_addr, line_base(a[0]));
        exp_line = init_line(line_base(a[0]));
        exp_line[a[0][`L2_OFFS_W-1:2]*`L2_WORD_W +: `L2_WORD_W] = d[0];
        check_line("written back line", last_wr_line, exp_line);
        for (int i = 0; i < 3; i++)
        begin
            access(read_req(a[i]), r, lat);
            check_word("core_resp_o.rdata", r.rdata, d[i]);
        end
        finish_test("same_set_eviction");
    endtask

    task automatic memory_error();
        addr_t      a;
        core_resp_t r;
        int         lat;
        a = rand_addr(6'd6);
        err_addr = line_base(a);
        access(read_req(a), r, lat);
        check_flag("core_resp_o.error", r.error, 1'b1);
        a = rand_addr(6'd7);
        access(read_req(a), r, lat);
        check_flag("core_resp_o.error", r.error, 1'b0);
        check_word("core_resp_o.rdata", r.rdata, init_word(a));
        finish_test("memory_error");
    endtask

    initial
    begin
        core_req  = '0;
        err_addr  = '0;
        lcg_state = 32'h909dccba;
        reset_sequence();
        read_miss_then_hit();
        write_hit_merge();
        write_miss_merge();
        same_set_eviction();
        memory_error();
        $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
        if (n_errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+hw
hw/l2_cache_pkg.sv
hw/l2_bus_pkg.sv
hw/l2_tag_array.sv
hw/l2_data_array.sv
hw/l2_cache_ctrl.sv
hw/l2_cache_core.sv
verif/tb_clk_gen.sv
verif/tb_mem_model.sv
verif/tb_l2_cache.sv

// ==== Makefile ====
# Verilator build and run of the L2 cache testbench

VERILATOR ?= verilator
FILELIST  ?= all.f
TOP       ?= tb_l2_cache
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)
